//--- gpu_decode.f
+incdir+sim
common/decode_pkg.sv
decode/imm_gen.sv
decode/op_decode.sv
decode/reg_usage.sv
design/pipe_buffer.sv
design/decode_top.sv
sim/decode_properties.sv
sim/decode_tb.sv

//--- Bender.yml
package:
  name: gpu_decode

sources:
  - common/decode_pkg.sv
  - decode/imm_gen.sv
  - decode/op_decode.sv
  - decode/reg_usage.sv
  - design/pipe_buffer.sv
  - design/decode_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/decode_properties.sv
      - sim/decode_tb.sv

//--- sim/decode_model.svh
// Reference decode function, scheduler lock rule and queue of expected decode items
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

decode_t exp_q[$];   // Accepted, not yet seen at the output

function automatic logic [19:0] sext12(input logic [11:0] v);
    return {{8{v[11]}}, v};
endfunction

// ECALL, EBREAK and MRET
function automatic logic is_env_instr(input logic [31:0] ins);
    return ins[6:0] == OPC_SYSTEM && ins[14:12] == 3'd0
        && (ins[31:20] == 12'h000 || ins[31:20] == 12'h001 || ins[31:20] == 12'h302);
endfunction

function automatic logic is_warp_instr(input logic [31:0] ins);
    return ins[6:0] == OPC_EXT1 && ins[31:25] == 7'd0
        && ins[14:12] inside {3'd0, 3'd1, 3'd2, 3'd3, 3'd5};
endfunction

// Jumps, branches, traps and warp control keep the warp locked
function automatic logic expect_unlock(input logic [31:0] ins);
    return !(ins[6:0] inside {OPC_JAL, OPC_JALR, OPC_BRANCH}
             || is_env_instr(ins) || is_warp_instr(ins));
endfunction

function automatic decode_t expect_decode(input fetch_t f);
    decode_t     d;
    logic [31:0] ins;
    logic [2:0]  f3;
    logic        rd_on;
    logic        rs1_on;
    logic        rs2_on;
    ins    = f.instr;
    f3     = ins[14:12];
    d      = '0;
    rd_on  = 1'b0;
    rs1_on = 1'b0;
    rs2_on = 1'b0;
    d.wid     = f.wid;
    d.tmask   = f.tmask;
    d.pc      = f.pc;
    d.ex_type = EX_ALU;
    case (ins[6:0])
        OPC_OP_IMM, OPC_OP: begin
            case (f3)
                3'd0: d.op_type = (ins[5] && ins[30]) ? ALU_SUB : ALU_ADD;
                3'd1: d.op_type = ALU_SLL;
                3'd2: d.op_type = ALU_SLT;
                3'd3: d.op_type = ALU_SLTU;
                3'd4: d.op_type = ALU_XOR;
                3'd5: d.op_type = ins[30] ? ALU_SRA : ALU_SRL;
                3'd6: d.op_type = ALU_OR;
                default: d.op_type = ALU_AND;
            endcase
            rd_on  = 1'b1;
            rs1_on = 1'b1;
            if (ins[5]) begin
                rs2_on = 1'b1;   // Register form
            end else begin
                d.use_imm = 1'b1;
                d.imm = (f3 == 3'd1 || f3 == 3'd5) ? {15'd0, ins[24:20]} : sext12(ins[31:20]);
            end
        end
        OPC_LUI, OPC_AUIPC: begin
            d.op_type = (ins[5]) ? ALU_LUI : ALU_AUIPC;
            d.use_pc  = !ins[5];
            d.use_imm = 1'b1;
            d.imm     = ins[31:12];
            rd_on     = 1'b1;
        end
        OPC_JAL, OPC_JALR: begin
            d.is_branch = 1'b1;
            d.use_imm   = 1'b1;
            d.op_type   = ins[3] ? BR_JAL : BR_JALR;
            d.use_pc    = ins[3];
            d.imm = ins[3] ? {ins[31], ins[19:12], ins[20], ins[30:21]} : sext12(ins[31:20]);
            rd_on  = 1'b1;
            rs1_on = !ins[3];
        end
        OPC_BRANCH: begin
            case (f3)
                3'd1: d.op_type = BR_BNE;
                3'd4: d.op_type = BR_BLT;
                3'd5: d.op_type = BR_BGE;
                3'd6: d.op_type = BR_BLTU;
                3'd7: d.op_type = BR_BGEU;
                default: d.op_type = BR_BEQ;
            endcase
            d.is_branch = 1'b1;
            d.use_pc    = 1'b1;
            d.use_imm   = 1'b1;
            d.imm       = sext12({ins[31], ins[7], ins[30:25], ins[11:8]});
            rs1_on      = 1'b1;
            rs2_on      = 1'b1;
        end
        OPC_LOAD, OPC_STORE: begin
            d.ex_type = EX_LSU;
            d.op_type = {ins[5], f3};   // Store bit over funct3
            d.use_imm = 1'b1;
            d.imm     = ins[5] ? sext12({ins[31:25], ins[11:7]}) : sext12(ins[31:20]);
            rd_on     = !ins[5];
            rs1_on    = 1'b1;
            rs2_on    = ins[5];
        end
        OPC_FENCE: begin
            d.ex_type = EX_LSU;
            d.op_type = LSU_FENCE;
        end
        OPC_SYSTEM: begin
            if (f3[1:0] != 2'b00) begin
                d.ex_type = EX_SFU;
                d.op_type = (f3[1:0] == 2'b01) ? SFU_CSRRW
                          : (f3[1:0] == 2'b10) ? SFU_CSRRS : SFU_CSRRC;
                d.use_imm = f3[2];
                d.imm     = {8'd0, ins[31:20]};
                rd_on     = 1'b1;
                rs1_on    = !f3[2];
            end else if (is_env_instr(ins)) begin
                d.op_type = (ins[31:20] == 12'h000) ? BR_ECALL
                          : (ins[31:20] == 12'h001) ? BR_EBREAK : BR_MRET;
                d.is_branch = 1'b1;
                d.use_pc    = 1'b1;
                d.use_imm   = 1'b1;
                d.imm       = 20'd4;
                rd_on       = 1'b1;
            end
        end
        OPC_EXT1: begin
            if (is_warp_instr(ins)) begin
                d.ex_type = EX_SFU;
                case (f3)
                    3'd0: d.op_type = SFU_TMC;
                    3'd1: d.op_type = SFU_WSPAWN;
                    3'd2: d.op_type = SFU_SPLIT;
                    3'd3: d.op_type = SFU_JOIN;
                    default: d.op_type = SFU_PRED;
                endcase
                rd_on  = (f3 == 3'd2);
                rs1_on = 1'b1;
                rs2_on = (f3 == 3'd1 || f3 == 3'd5);
            end
        end
        default: ;
    endcase
    d.rd      = rd_on  ? ins[11:7]  : 5'd0;
    d.rs1     = rs1_on ? ins[19:15] : 5'd0;
    d.rs2     = rs2_on ? ins[24:20] : 5'd0;
    d.used_rs = {rs2_on, rs1_on};
    d.wb      = rd_on && (ins[11:7] != 5'd0);
    return d;
endfunction

`endif

//--- sim/decode_tb.sv
// Testbench for the decode stage with random instructions, scoreboard and reporting
module decode_tb import decode_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int TOTAL_ITEMS = 1900;   // Sum of all test lengths

    logic    clk;
    logic    rst_n;
    logic    fetch_valid;
    logic    fetch_ready;
    fetch_t  fetch_data;
    logic    dec_valid;
    logic    dec_ready;
    decode_t dec_data;
    sched_t  sched;

    integer seed;
    string  cur_test = "reset";
    int     err_count;
    int     check_count;
    int     test_count;
    int     item_count;
    int     assert_fails;

    `include "decode_model.svh"

    decode_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_data    (dec_data),
        .sched       (sched)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_value(input string what, input logic [127:0] expected,
                                 input logic [127:0] actual);
        check_count++;
        if (expected !== actual) begin
            err_count++;
            $display("ERR %s %s expected %h actual %h", cur_test, what, expected, actual);
        end
    endtask

    // Kind 0 ALU, 1 branch, 2 LSU, 3 SFU, 4 any
    function logic [31:0] pick_instr(input int kind);
        logic [31:0] r;
        logic [2:0]  f3;
        int          k;
        int          sel;
        r   = $random(seed);
        sel = $unsigned($random(seed)) % 4;
        k   = (kind == 4) ? $unsigned($random(seed)) % 4 : kind;
        if (($random(seed) & 7) == 0)
            return r;   // Raw word, mostly unknown opcodes
        case (k * 4 + sel)
            0: begin
                f3 = r[14:12];
                return {(f3[1:0] == 2'b01) ? {1'b0, r[30], 5'd0} : r[31:25],
                        r[24:15], f3, r[11:7], OPC_OP_IMM};
            end
            1:  return {1'b0, r[30], 5'd0, r[24:7], OPC_OP};
            2:  return {r[31:7], OPC_LUI};
            3:  return {r[31:7], OPC_AUIPC};
            4:  return {r[31:7], OPC_BRANCH};
            5:  return {r[31:7], OPC_JAL};
            6:  return {r[31:15], 3'd0, r[11:7], OPC_JALR};
            7:  return {(r[1:0] == 2'd0) ? 12'h000 : (r[1:0] == 2'd1) ? 12'h001 : 12'h302,
                        8'd0, r[11:7], OPC_SYSTEM};
            9:  return {r[31:15], 1'b0, r[13:7], OPC_STORE};
            10: return {r[31:7], OPC_FENCE};
            12, 13: begin
                f3 = {r[14], (r[13:12] == 2'b00) ? 2'b01 : r[13:12]};
                return {r[31:15], f3, r[11:7], OPC_SYSTEM};
            end
            14, 15: begin
                case (r[2:0])
                    3'd0, 3'd1, 3'd2, 3'd3: f3 = r[2:0];
                    3'd4: f3 = 3'd5;            // PRED
                    default: f3 = r[14:12];
                endcase
                return {(r[31:29] == 3'd0) ? r[31:25] : 7'd0, r[24:15], f3, r[11:7], OPC_EXT1};
            end
            default: return {r[31:7], OPC_LOAD};
        endcase
    endfunction

    function fetch_t make_fetch(input int kind);
        fetch_t f;
        f.wid   = $random(seed);
        f.tmask = $random(seed);
        f.pc    = $random(seed) & ~32'd3;
        f.instr = pick_instr(kind);
        return f;
    endfunction

    // Scoreboard on both handshakes
    always @(posedge clk) begin
        decode_t head;
        if (rst_n) begin
            compare_value("fetch_ready", exp_q.size() < 2, fetch_ready);
            compare_value("dec_valid", exp_q.size() != 0, dec_valid);
            compare_value("sched.valid", fetch_valid && exp_q.size() < 2, sched.valid);
            if (dec_valid && dec_ready && exp_q.size() != 0) begin
                head = exp_q.pop_front();
                compare_value("dec_data", head, dec_data);
            end
            if (fetch_valid && fetch_ready) begin
                compare_value("sched.wid", fetch_data.wid, sched.wid);
                compare_value("sched.unlock", expect_unlock(fetch_data.instr), sched.unlock);
                exp_q.push_back(expect_decode(fetch_data));
            end
        end
    end

    // ready_q is dec_ready probability in quarters
    task automatic run_test(input string name, input int kind, input int count,
                            input int ready_q);
        int   sent;
        int   errs_start;
        logic taken;
        cur_test   = name;
        errs_start = err_count;
        sent       = 0;
        while (sent < count) begin
            @(posedge clk);
            taken = fetch_valid && fetch_ready;
            if (taken)
                sent++;
            if (sent == count) begin
                fetch_valid <= 1'b0;
            end else if (!fetch_valid || taken) begin
                fetch_valid <= (($random(seed) & 3) != 0);   // Some idle cycles
                fetch_data  <= make_fetch(kind);
            end
            dec_ready <= ($unsigned($random(seed)) % 4) < ready_q;
        end
        @(negedge clk);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            dec_ready <= ($unsigned($random(seed)) % 4) < ready_q;
            @(negedge clk);
        end
        test_count++;
        item_count += count;
        $display("Test %-12s %0d items, %0d errors", name, count, err_count - errs_start);
    endtask

    initial begin
        seed        = 32'h708e_5cd4;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        dec_ready   = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        run_test("alu", 0, 300, 3);
        run_test("branch", 1, 300, 3);
        run_test("lsu", 2, 300, 3);
        run_test("sfu", 3, 300, 3);
        run_test("backpressure", 4, 300, 1);
        run_test("mixed", 4, 400, 2);
        assert_fails = uut.u_props.fail_count;
        $display("Summary: %0d tests, %0d items, %0d checks, %0d errors, %0d assertion failures",
                 test_count, item_count, check_count, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #((TOTAL_ITEMS * 10 + 50) * CLK_PERIOD);
        $display("Watchdog expired with the tests still running in %s", cur_test);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- sim/decode_properties.sv
// Concurrent assertions on reset state, stalled output stability and scheduler notify
module decode_properties import decode_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    fetch_valid,
    input logic    fetch_ready,
    input logic    dec_valid,
    input logic    dec_ready,
    input decode_t dec_data,
    input sched_t  sched
);

    int fail_count = 0;   // Assertion failures so far

    // Nothing leaves the stage right after reset
    reset_idle: assert property (@(posedge clk) !rst_n |=> !dec_valid && !sched.valid)
        else begin
            fail_count++;
            $error("dec_valid or sched.valid high in the cycle after reset");
        end

    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_data))
        else begin
            fail_count++;
            $error("dec_data changed or dropped while stalled");
        end

    sched_match: assert property (@(posedge clk) disable iff (!rst_n)
        sched.valid == (fetch_valid && fetch_ready))
        else begin
            fail_count++;
            $error("sched.valid differs from the fetch handshake");
        end

endmodule

bind decode_top decode_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_data    (dec_data),
    .sched       (sched)
);

//--- design/decode_top.sv
// Decode stage top level with decoders, output buffer and scheduler notify
module decode_top import decode_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    fetch_valid,
    output logic    fetch_ready,
    input  fetch_t  fetch_data,
    output logic    dec_valid,
    input  logic    dec_ready,
    output decode_t dec_data,
    output sched_t  sched
);

    ex_type_e    ex_type;
    logic [3:0]  op_type;
    logic        is_branch;
    logic        use_pc;
    logic        use_imm;
    imm_sel_e    imm_sel;
    logic        is_wstall;
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [1:0]  used_rs;
    logic        wb;
    decode_t     dec_in;

    op_decode u_op_decode (
        .instr     (fetch_data.instr),
        .ex_type   (ex_type),
        .op_type   (op_type),
        .is_branch (is_branch),
        .use_pc    (use_pc),
        .use_imm   (use_imm),
        .imm_sel   (imm_sel),
        .is_wstall (is_wstall)
    );

    imm_gen u_imm_gen (
        .instr   (fetch_data.instr),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    reg_usage u_reg_usage (
        .instr   (fetch_data.instr),
        .rd      (rd),
        .rs1     (rs1),
        .rs2     (rs2),
        .used_rs (used_rs),
        .wb      (wb)
    );

    always_comb begin
        dec_in.wid       = fetch_data.wid;
        dec_in.tmask     = fetch_data.tmask;
        dec_in.pc        = fetch_data.pc;
        dec_in.ex_type   = ex_type;
        dec_in.op_type   = op_type;
        dec_in.is_branch = is_branch;
        dec_in.use_pc    = use_pc;
        dec_in.use_imm   = use_imm;
        dec_in.imm       = imm;
        dec_in.wb        = wb;
        dec_in.used_rs   = used_rs;
        dec_in.rd        = rd;
        dec_in.rs1       = rs1;
        dec_in.rs2       = rs2;
    end

    pipe_buffer u_pipe_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (dec_in),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec_data)
    );

    // Scheduler sees every accepted instruction, control flow keeps the warp locked
    assign sched.valid  = fetch_valid && fetch_ready;
    assign sched.wid    = fetch_data.wid;
    assign sched.unlock = !is_wstall;

endmodule

//--- design/pipe_buffer.sv
// Two-entry valid/ready elastic buffer for decoded items
module pipe_buffer import decode_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    output logic    in_ready,
    input  decode_t in_data,
    output logic    out_valid,
    input  logic    out_ready,
    output decode_t out_data
);

    decode_t    mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push)
                wr_ptr <= !wr_ptr;
            if (pop)
                rd_ptr <= !rd_ptr;
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

//--- decode/reg_usage.sv
// Register id extraction, source-use flags and writeback enable
module reg_usage import decode_pkg::*; (
    input  logic [31:0] instr,
    output logic [4:0]  rd,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [1:0]  used_rs,
    output logic        wb
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_env;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // ECALL, EBREAK, MRET
    assign is_env = (funct3 == 3'h0)
                 && (instr[31:20] == 12'h000 || instr[31:20] == 12'h001
                     || instr[31:20] == 12'h302);

    always_comb begin
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_OP_IMM, OPC_JALR, OPC_LOAD: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            OPC_OP: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_LUI, OPC_AUIPC, OPC_JAL: use_rd = 1'b1;
            OPC_BRANCH, OPC_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_SYSTEM: begin
                if (funct3[1:0] != 2'b00) begin
                    use_rd  = 1'b1;
                    use_rs1 = !funct3[2];  // rs1 field is uimm otherwise
                end else begin
                    use_rd  = is_env;
                end
            end
            OPC_EXT1: begin
                if (instr[31:25] == 7'h00) begin
                    case (funct3)
                        3'h0, 3'h3: use_rs1 = 1'b1;    // TMC, JOIN
                        3'h1, 3'h5: begin              // WSPAWN, PRED
                            use_rs1 = 1'b1;
                            use_rs2 = 1'b1;
                        end
                        3'h2: begin                    // SPLIT
                            use_rd  = 1'b1;
                            use_rs1 = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

    assign rd      = use_rd  ? instr[11:7]  : 5'd0;
    assign rs1     = use_rs1 ? instr[19:15] : 5'd0;
    assign rs2     = use_rs2 ? instr[24:20] : 5'd0;
    assign used_rs = {use_rs2, use_rs1};
    assign wb      = use_rd && (rd != 5'd0);   // Never write x0

endmodule

//--- decode/op_decode.sv
// Opcode and function field decoder giving unit, operation, operand flags and warp stall
module op_decode import decode_pkg::*; (
    input  logic [31:0] instr,
    output ex_type_e    ex_type,
    output logic [3:0]  op_type,
    output logic        is_branch,
    output logic        use_pc,
    output logic        use_imm,
    output imm_sel_e    imm_sel,
    output logic        is_wstall
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] u_12;
    logic        is_shift;

    alu_op_e r_op;
    br_op_e  b_op;
    br_op_e  s_op;
    logic    s_ok;
    sfu_op_e w_op;
    logic    w_ok;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign u_12     = instr[31:20];
    assign is_shift = funct3[0] && !funct3[1];

    always_comb begin
        case (funct3)
            3'h0: r_op = (opcode[5] && funct7[5]) ? ALU_SUB : ALU_ADD;  // No SUBI
            3'h1: r_op = ALU_SLL;
            3'h2: r_op = ALU_SLT;
            3'h3: r_op = ALU_SLTU;
            3'h4: r_op = ALU_XOR;
            3'h5: r_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'h6: r_op = ALU_OR;
            default: r_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h1: b_op = BR_BNE;
            3'h4: b_op = BR_BLT;
            3'h5: b_op = BR_BGE;
            3'h6: b_op = BR_BLTU;
            3'h7: b_op = BR_BGEU;
            default: b_op = BR_BEQ;  // Reserved funct3 falls back to BEQ
        endcase
    end

    // ECALL, EBREAK, MRET
    always_comb begin
        s_ok = (funct3 == 3'h0);
        case (u_12)
            12'h000: s_op = BR_ECALL;
            12'h001: s_op = BR_EBREAK;
            12'h302: s_op = BR_MRET;
            default: begin
                s_op = BR_ECALL;
                s_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        w_ok = (funct7 == 7'h00);
        case (funct3)
            3'h0: w_op = SFU_TMC;
            3'h1: w_op = SFU_WSPAWN;
            3'h2: w_op = SFU_SPLIT;
            3'h3: w_op = SFU_JOIN;
            3'h5: w_op = SFU_PRED;
            default: begin
                w_op = SFU_TMC;
                w_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        ex_type   = EX_ALU;
        op_type   = '0;
        is_branch = 1'b0;
        use_pc    = 1'b0;
        use_imm   = 1'b0;
        imm_sel   = IMM_NONE;
        is_wstall = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                op_type = r_op;
                use_imm = 1'b1;
                imm_sel = is_shift ? IMM_SH : IMM_I;
            end
            OPC_OP:     op_type = r_op;
            OPC_LUI: begin
                op_type = ALU_LUI;
                use_imm = 1'b1;
                imm_sel = IMM_U;
            end
            OPC_AUIPC: begin
                op_type = ALU_AUIPC;
                use_pc  = 1'b1;
                use_imm = 1'b1;
                imm_sel = IMM_U;
            end
            OPC_JAL: begin
                op_type   = BR_JAL;
                is_branch = 1'b1;
                use_pc    = 1'b1;
                use_imm   = 1'b1;
                imm_sel   = IMM_J;
                is_wstall = 1'b1;
            end
            OPC_JALR: begin
                op_type   = BR_JALR;
                is_branch = 1'b1;
                use_imm   = 1'b1;
                imm_sel   = IMM_I;
                is_wstall = 1'b1;
            end
            OPC_BRANCH: begin
                op_type   = b_op;
                is_branch = 1'b1;
                use_pc    = 1'b1;
                use_imm   = 1'b1;
                imm_sel   = IMM_B;
                is_wstall = 1'b1;
            end
            OPC_LOAD: begin
                ex_type = EX_LSU;
                op_type = {1'b0, funct3};
                use_imm = 1'b1;
                imm_sel = IMM_I;
            end
            OPC_STORE: begin
                ex_type = EX_LSU;
                op_type = {1'b1, funct3};
                use_imm = 1'b1;
                imm_sel = IMM_S;
            end
            OPC_FENCE: begin
                ex_type = EX_LSU;
                op_type = LSU_FENCE;
            end
            OPC_SYSTEM: begin
                if (funct3[1:0] != 2'b00) begin
                    ex_type = EX_SFU;
                    case (funct3[1:0])
                        2'b01:   op_type = SFU_CSRRW;
                        2'b10:   op_type = SFU_CSRRS;
                        default: op_type = SFU_CSRRC;
                    endcase
                    use_imm = funct3[2];   // Immediate forms
                    imm_sel = IMM_CSR;
                end else if (s_ok) begin
                    op_type   = s_op;
                    is_branch = 1'b1;
                    use_pc    = 1'b1;
                    use_imm   = 1'b1;
                    imm_sel   = IMM_SYS;
                    is_wstall = 1'b1;
                end
            end
            OPC_EXT1: begin
                if (w_ok) begin
                    ex_type   = EX_SFU;
                    op_type   = w_op;
                    is_wstall = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- decode/imm_gen.sv
// Immediate generator for the RISC-V instruction formats
module imm_gen import decode_pkg::*; (
    input  logic [31:0] instr,
    input  imm_sel_e    imm_sel,
    output logic [19:0] imm
);

    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [11:0] b_imm;
    logic [19:0] u_imm;
    logic [19:0] j_imm;

    assign i_imm = instr[31:20];
    assign s_imm = {instr[31:25], instr[11:7]};
    assign b_imm = {instr[31], instr[7], instr[30:25], instr[11:8]};   // Halfword offset
    assign u_imm = instr[31:12];
    assign j_imm = {instr[31], instr[19:12], instr[20], instr[30:21]};

    always_comb begin
        case (imm_sel)
            IMM_I:   imm = {{8{i_imm[11]}}, i_imm};
            IMM_SH:  imm = {15'd0, instr[24:20]};  // Shamt only
            IMM_S:   imm = {{8{s_imm[11]}}, s_imm};
            IMM_B:   imm = {{8{b_imm[11]}}, b_imm};
            IMM_U:   imm = u_imm;
            IMM_J:   imm = j_imm;
            IMM_CSR: imm = {8'd0, instr[31:20]};   // CSR address
            // Link offset for trap and return
            IMM_SYS: imm = 20'd4;
            default: imm = '0;
        endcase
    end

endmodule

//--- common/decode_pkg.sv
// Decode stage constants, opcode and operation enums, fetch, decode and scheduler structs
package decode_pkg;

    localparam int NUM_WARPS   = 4;
    localparam int NUM_THREADS = 4;
    localparam int WID_BITS    = $clog2(NUM_WARPS);

    localparam logic [3:0] LSU_FENCE = 4'd15;   // Above all load/store codes

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    // RV32I major opcodes plus custom-0 for warp control
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011,
        OPC_EXT1   = 7'b0001011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU,
        BR_JAL, BR_JALR, BR_ECALL, BR_EBREAK, BR_MRET
    } br_op_e;

    typedef enum logic [3:0] {
        SFU_TMC, SFU_WSPAWN, SFU_SPLIT, SFU_JOIN, SFU_PRED,
        SFU_CSRRW, SFU_CSRRS, SFU_CSRRC
    } sfu_op_e;

    // Immediate format requested from imm_gen
    typedef enum logic [3:0] {
        IMM_NONE, IMM_I, IMM_SH, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CSR, IMM_SYS
    } imm_sel_e;

    typedef struct packed {
        logic [WID_BITS-1:0]    wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [31:0]            pc;
        logic [31:0]            instr;
    } fetch_t;

    typedef struct packed {
        logic [WID_BITS-1:0]    wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [31:0]            pc;
        ex_type_e               ex_type;
        logic [3:0]             op_type;
        logic                   is_branch;
        logic                   use_pc;
        logic                   use_imm;
        logic [19:0]            imm;
        logic                   wb;
        logic [1:0]             used_rs;    // Bit 0 rs1, bit 1 rs2
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
    } decode_t;

    typedef struct packed {
        logic                valid;
        logic [WID_BITS-1:0] wid;
        logic                unlock;
    } sched_t;

endpackage
